//--- tcdm_consts.svh
// Sizing macros for the TCDM subsystem: ports, banks, widths and bank depth
`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// Core-side request ports
`define TCDM_NUM_IN 4

// Word-interleaved banks, power of two
`define TCDM_NUM_OUT 4

// Byte address and word widths
`define TCDM_ADDR_WIDTH 32
`define TCDM_DATA_WIDTH 32

// Byte enables per word
`define TCDM_BE_WIDTH (`TCDM_DATA_WIDTH / 8)

// Words per bank and the row index that selects one
`define TCDM_BANK_WORDS 64
`define TCDM_BANK_ROW_WIDTH 6

`endif

//--- tcdm_pkg.sv
// Request, response and bank payload structs of the TCDM subsystem
`include "tcdm_consts.svh"

package tcdm_pkg;

    // Request payload seen by the crossbar
    typedef struct packed {
        logic [`TCDM_ADDR_WIDTH-1:0] addr;
        logic                        write;
        logic [`TCDM_DATA_WIDTH-1:0] data;
        logic [`TCDM_BE_WIDTH-1:0]   strb;
    } tcdm_req_payload_t;

    // Held until q_ready
    typedef struct packed {
        logic              q_valid;
        tcdm_req_payload_t q;
    } mem_req_t;

    // Valid pulses one cycle after the transfer
    typedef struct packed {
        logic                        valid;
        logic [`TCDM_DATA_WIDTH-1:0] data;
    } tcdm_rsp_payload_t;

    typedef struct packed {
        logic              q_ready;
        tcdm_rsp_payload_t p;
    } mem_rsp_t;

    // One bank access, always accepted
    typedef struct packed {
        logic                            req;
        logic [`TCDM_BANK_ROW_WIDTH-1:0] row;
        logic                            write;
        logic [`TCDM_DATA_WIDTH-1:0]     wdata;
        logic [`TCDM_BE_WIDTH-1:0]       be;
    } tcdm_bank_req_t;

endpackage

//--- tcdm_rr_arbiter.sv
// Round-robin arbiter with one-hot grant and winner index
`include "tcdm_consts.svh"

module tcdm_rr_arbiter #(
    parameter int unsigned NUM_REQ = `TCDM_NUM_IN,
    localparam int unsigned IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [NUM_REQ-1:0] req_i,
    output logic [NUM_REQ-1:0] gnt_o,
    output logic [IDX_W-1:0]   idx_o
);

    // Requester with highest priority this cycle
    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] ptr_d;
    logic             found;

    // First requester at or after the pointer wins
    always_comb begin
        int unsigned cand;
        gnt_o = '0;
        idx_o = '0;
        found = 1'b0;
        cand  = 0;
        for (int unsigned k = 0; k < NUM_REQ; k++) begin
            cand = (32'(ptr_q) + k) % NUM_REQ;
            if (!found && req_i[cand]) begin
                found       = 1'b1;
                gnt_o[cand] = 1'b1;
                idx_o       = IDX_W'(cand);
            end
        end
    end

    // Next priority goes to the one after the winner
    always_comb begin
        if (32'(idx_o) == NUM_REQ - 1) begin
            ptr_d = '0;
        end else begin
            ptr_d = idx_o + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (found) begin
            ptr_q <= ptr_d;
        end
    end

endmodule

//--- tcdm_interconnect.sv
// Flat-port logarithmic crossbar with bank decode, arbitration and response routing
`include "tcdm_consts.svh"

module tcdm_interconnect
    import tcdm_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,

    // Core side
    input  logic [`TCDM_NUM_IN-1:0]                        req_i,
    input  logic [`TCDM_NUM_IN-1:0][`TCDM_ADDR_WIDTH-1:0]  add_i,
    input  logic [`TCDM_NUM_IN-1:0]                        wen_i,
    input  logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0]  wdata_i,
    input  logic [`TCDM_NUM_IN-1:0][`TCDM_BE_WIDTH-1:0]    be_i,
    output logic [`TCDM_NUM_IN-1:0]                        gnt_o,
    output logic [`TCDM_NUM_IN-1:0]                        vld_o,
    output logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0]  rdata_o,

    // Bank side
    output tcdm_bank_req_t [`TCDM_NUM_OUT-1:0]                bank_req_o,
    input  logic [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0]    bank_rdata_i
);

    localparam int unsigned NUM_IN     = `TCDM_NUM_IN;
    localparam int unsigned NUM_OUT    = `TCDM_NUM_OUT;
    localparam int unsigned ROW_W      = `TCDM_BANK_ROW_WIDTH;
    localparam int unsigned BYTE_OFF_W = $clog2(`TCDM_BE_WIDTH);
    localparam int unsigned BANK_SEL_W = $clog2(NUM_OUT);
    localparam int unsigned ROW_LSB    = BYTE_OFF_W + BANK_SEL_W;
    localparam int unsigned PORT_IDX_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

    logic [NUM_IN-1:0][BANK_SEL_W-1:0] port_bank;
    logic [NUM_IN-1:0][ROW_W-1:0]      port_row;

    logic [NUM_OUT-1:0][NUM_IN-1:0]     bank_reqs;
    logic [NUM_OUT-1:0][NUM_IN-1:0]     bank_gnts;
    logic [NUM_OUT-1:0][PORT_IDX_W-1:0] win_idx;

    // Response route, one entry per bank
    logic [NUM_OUT-1:0]                 route_vld_q;
    logic [NUM_OUT-1:0][PORT_IDX_W-1:0] route_idx_q;
    logic [NUM_OUT-1:0]                 route_wr_q;

    // Low word-address bits pick the bank
    for (genvar i = 0; i < NUM_IN; i++) begin : gen_decode
        assign port_bank[i] = add_i[i][BYTE_OFF_W +: BANK_SEL_W];
        assign port_row[i]  = add_i[i][ROW_LSB +: ROW_W];
    end

    for (genvar b = 0; b < NUM_OUT; b++) begin : gen_bank
        for (genvar i = 0; i < NUM_IN; i++) begin : gen_port
            assign bank_reqs[b][i] = req_i[i] && (port_bank[i] == BANK_SEL_W'(b));
        end

        tcdm_rr_arbiter #(
            .NUM_REQ(NUM_IN)
        ) u_arbiter (
            .clk_i  (clk_i),
            .rst_n_i(rst_n_i),
            .req_i  (bank_reqs[b]),
            .gnt_o  (bank_gnts[b]),
            .idx_o  (win_idx[b])
        );

        // Winner fields to the bank
        assign bank_req_o[b].req   = |bank_reqs[b];
        assign bank_req_o[b].row   = port_row[win_idx[b]];
        assign bank_req_o[b].write = wen_i[win_idx[b]];
        assign bank_req_o[b].wdata = wdata_i[win_idx[b]];
        assign bank_req_o[b].be    = be_i[win_idx[b]];
    end

    // A port asks one bank at a time, so at most one bank grants it
    always_comb begin
        gnt_o = '0;
        for (int unsigned b = 0; b < NUM_OUT; b++) begin
            gnt_o |= bank_gnts[b];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            route_vld_q <= '0;
            route_idx_q <= '0;
            route_wr_q  <= '0;
        end else begin
            for (int unsigned b = 0; b < NUM_OUT; b++) begin
                route_vld_q[b] <= bank_req_o[b].req;
                route_idx_q[b] <= win_idx[b];
                route_wr_q[b]  <= bank_req_o[b].write;
            end
        end
    end

    // Writes answer with zero data
    always_comb begin
        vld_o   = '0;
        rdata_o = '0;
        for (int unsigned b = 0; b < NUM_OUT; b++) begin
            if (route_vld_q[b]) begin
                vld_o[route_idx_q[b]] = 1'b1;
                if (!route_wr_q[b]) begin
                    rdata_o[route_idx_q[b]] = bank_rdata_i[b];
                end
            end
        end
    end

endmodule

//--- tcdm_interconnect_wrap.sv
// Struct-to-flat adapter around the TCDM crossbar
`include "tcdm_consts.svh"

module tcdm_interconnect_wrap
    import tcdm_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,

    input  mem_req_t [`TCDM_NUM_IN-1:0] mem_req_i,
    output mem_rsp_t [`TCDM_NUM_IN-1:0] mem_rsp_o,

    output tcdm_bank_req_t [`TCDM_NUM_OUT-1:0]             bank_req_o,
    input  logic [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0] bank_rdata_i
);

    logic [`TCDM_NUM_IN-1:0]                       req_valid;
    logic [`TCDM_NUM_IN-1:0][`TCDM_ADDR_WIDTH-1:0] req_addr;
    logic [`TCDM_NUM_IN-1:0]                       req_write;
    logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] req_data;
    logic [`TCDM_NUM_IN-1:0][`TCDM_BE_WIDTH-1:0]   req_strb;
    logic [`TCDM_NUM_IN-1:0]                       rsp_ready;
    logic [`TCDM_NUM_IN-1:0]                       rsp_valid;
    logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] rsp_data;

    for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_port
        assign req_valid[i] = mem_req_i[i].q_valid;
        assign req_addr[i]  = mem_req_i[i].q.addr;
        assign req_write[i] = mem_req_i[i].q.write;
        assign req_data[i]  = mem_req_i[i].q.data;
        assign req_strb[i]  = mem_req_i[i].q.strb;

        // Grant is the same-cycle q_ready
        assign mem_rsp_o[i].q_ready = rsp_ready[i];
        assign mem_rsp_o[i].p.valid = rsp_valid[i];
        assign mem_rsp_o[i].p.data  = rsp_data[i];
    end

    tcdm_interconnect u_tcdm_interconnect (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_valid),
        .add_i       (req_addr),
        .wen_i       (req_write),
        .wdata_i     (req_data),
        .be_i        (req_strb),
        .gnt_o       (rsp_ready),
        .vld_o       (rsp_valid),
        .rdata_o     (rsp_data),
        .bank_req_o  (bank_req_o),
        .bank_rdata_i(bank_rdata_i)
    );

endmodule

//--- tcdm_sram_bank.sv
// Single-port SRAM bank with byte-strobed writes and registered read data
`include "tcdm_consts.svh"

module tcdm_sram_bank
    import tcdm_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  tcdm_bank_req_t              bank_req_i,
    output logic [`TCDM_DATA_WIDTH-1:0] rdata_o
);

    localparam int unsigned BE_W = `TCDM_BE_WIDTH;

    logic [`TCDM_DATA_WIDTH-1:0] mem_q [`TCDM_BANK_WORDS];

    logic do_write;
    logic do_read;

    assign do_write = bank_req_i.req && bank_req_i.write;
    assign do_read  = bank_req_i.req && !bank_req_i.write;

    // Only strobed bytes change
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            for (int unsigned b = 0; b < BE_W; b++) begin
                if (bank_req_i.be[b]) begin
                    mem_q[bank_req_i.row][8*b +: 8] <= bank_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Holds the last read word between reads
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (do_read) begin
            rdata_o <= mem_q[bank_req_i.row];
        end
    end

endmodule

//--- tcdm_cluster_top.sv
// TCDM cluster top: crossbar wrapper and the array of SRAM banks
`include "tcdm_consts.svh"

module tcdm_cluster_top
    import tcdm_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  mem_req_t [`TCDM_NUM_IN-1:0] mem_req_i,
    output mem_rsp_t [`TCDM_NUM_IN-1:0] mem_rsp_o
);

    tcdm_bank_req_t [`TCDM_NUM_OUT-1:0]             bank_req;
    logic [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0] bank_rdata;

    tcdm_interconnect_wrap u_tcdm_interconnect_wrap (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mem_req_i   (mem_req_i),
        .mem_rsp_o   (mem_rsp_o),
        .bank_req_o  (bank_req),
        .bank_rdata_i(bank_rdata)
    );

    // Bank b holds word addresses with low bits equal to b
    for (genvar b = 0; b < `TCDM_NUM_OUT; b++) begin : gen_bank
        tcdm_sram_bank u_tcdm_sram_bank (
            .clk_i     (clk_i),
            .rst_n_i   (rst_n_i),
            .bank_req_i(bank_req[b]),
            .rdata_o   (bank_rdata[b])
        );
    end

endmodule

//--- tcdm_props.sv
// Bound assertions on crossbar grants, request hold and response timing
`include "tcdm_consts.svh"

module tcdm_props (
    input logic                                          clk_i,
    input logic                                          rst_n_i,
    input logic [`TCDM_NUM_IN-1:0]                       req_i,
    input logic [`TCDM_NUM_IN-1:0][`TCDM_ADDR_WIDTH-1:0] add_i,
    input logic [`TCDM_NUM_IN-1:0]                       wen_i,
    input logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] wdata_i,
    input logic [`TCDM_NUM_IN-1:0][`TCDM_BE_WIDTH-1:0]   be_i,
    input logic [`TCDM_NUM_IN-1:0]                       gnt_i,
    input logic [`TCDM_NUM_IN-1:0]                       vld_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned BANK_LSB   = $clog2(`TCDM_BE_WIDTH);
    localparam int unsigned BANK_SEL_W = $clog2(`TCDM_NUM_OUT);

    // Granted ports sorted by the bank they address
    logic [`TCDM_NUM_OUT-1:0][`TCDM_NUM_IN-1:0] bank_gnts;

    for (genvar b = 0; b < `TCDM_NUM_OUT; b++) begin : gen_bank
        for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_port
            assign bank_gnts[b][i] = gnt_i[i]
                && (add_i[i][BANK_LSB +: BANK_SEL_W] == BANK_SEL_W'(b));
        end

        // At most one winner per bank
        assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(bank_gnts[b]))
            else $error("bank %0d granted more than one port", b);
    end

    for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_port
        // Losing master keeps its request unchanged
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            req_i[i] && !gnt_i[i] |=> req_i[i] && $stable(add_i[i]) && $stable(wen_i[i])
                && $stable(wdata_i[i]) && $stable(be_i[i]))
            else $error("port %0d dropped or changed a request before its grant", i);

        // Response pulse one cycle after the grant
        assert property (@(posedge clk_i) disable iff (!rst_n_i) vld_i[i] == $past(gnt_i[i]))
            else $error("port %0d response does not follow its grant", i);
    end

endmodule

bind tcdm_interconnect tcdm_props u_tcdm_props (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (req_i),
    .add_i  (add_i),
    .wen_i  (wen_i),
    .wdata_i(wdata_i),
    .be_i   (be_i),
    .gnt_i  (gnt_o),
    .vld_i  (vld_o)
);

//--- tb_tcdm_cluster.sv
// Directed testbench for the TCDM cluster with a reference memory model
`include "tcdm_consts.svh"

module tb_tcdm_cluster
    import tcdm_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_IN   = `TCDM_NUM_IN;
    localparam int NUM_OUT  = `TCDM_NUM_OUT;
    localparam int ROWS     = `TCDM_BANK_WORDS;
    localparam int ROW_LSB  = 2 + $clog2(NUM_OUT);
    localparam int ADDR_TOP = ROW_LSB + `TCDM_BANK_ROW_WIDTH;
    localparam int RAND_OPS = 16;
    // Init, partial write, distinct banks, one bank, back-to-back, random
    localparam int PLANNED_REQS = NUM_OUT * ROWS + 2 + 2 * NUM_IN + NUM_IN + 8
                                  + NUM_IN * RAND_OPS;
    localparam int CYCLE_LIMIT = 4 * PLANNED_REQS * NUM_IN;

    logic                  clk = 1'b0;
    logic                  rst_n;
    mem_req_t [NUM_IN-1:0] mem_req;
    mem_rsp_t [NUM_IN-1:0] mem_rsp;

    logic [31:0]       ref_mem [NUM_OUT][ROWS];
    logic [31:0]       exp_data [NUM_IN];
    logic [31:0]       last_data [NUM_IN];
    logic [NUM_IN-1:0] pending = '0;
    int                last_winner [NUM_OUT];
    int                grant_log [$];
    int                cycle_count = 0;
    logic [31:0]       rng_state = 32'habc1;
    tcdm_req_payload_t port_q [NUM_IN][$];

    tcdm_cluster_top u_tcdm_cluster_top (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .mem_req_i(mem_req),
        .mem_rsp_o(mem_rsp)
    );

    always #4 clk = ~clk;

    task automatic fail_with(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_with($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    function automatic int bank_of(input logic [31:0] addr);
        return int'(addr[2 +: $clog2(NUM_OUT)]);
    endfunction

    function automatic int row_of(input logic [31:0] addr);
        return int'(addr[ROW_LSB +: `TCDM_BANK_ROW_WIDTH]);
    endfunction

    function automatic logic [31:0] make_addr(input int bank, input int row);
        return (32'(row) << ROW_LSB) | (32'(bank) << 2);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) res[8*k +: 8] = wdata[8*k +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic queue_req(input int port, input logic write, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
        tcdm_req_payload_t item;
        item.addr  = addr;
        item.write = write;
        item.data  = data;
        item.strb  = strb;
        port_q[port].push_back(item);
    endtask

    // Response check first, then this cycle's transfers against the model
    always @(negedge clk) begin
        logic [NUM_IN-1:0] xfer;
        if (rst_n) begin
            for (int p = 0; p < NUM_IN; p++) begin
                if (pending[p] != mem_rsp[p].p.valid) begin
                    fail_with($sformatf("Port %0d: p.valid is %0b at %0t but a transfer %s",
                        p, mem_rsp[p].p.valid, $time, pending[p] ? "was made" : "was not made"));
                end
                if (pending[p]) begin
                    check_value($sformatf("mem_rsp[%0d].p.data", p), mem_rsp[p].p.data,
                                exp_data[p]);
                    last_data[p] = mem_rsp[p].p.data;
                end
                xfer[p] = mem_req[p].q_valid && mem_rsp[p].q_ready;
                if (xfer[p]) begin
                    exp_data[p] = mem_req[p].q.write ? '0 :
                        ref_mem[bank_of(mem_req[p].q.addr)][row_of(mem_req[p].q.addr)];
                    last_winner[bank_of(mem_req[p].q.addr)] = p;
                    grant_log.push_back(p);
                end
            end
            // Writes land after all reads of the same cycle
            for (int p = 0; p < NUM_IN; p++) begin
                if (xfer[p] && mem_req[p].q.write) begin
                    ref_mem[bank_of(mem_req[p].q.addr)][row_of(mem_req[p].q.addr)] = merge_bytes(
                        ref_mem[bank_of(mem_req[p].q.addr)][row_of(mem_req[p].q.addr)],
                        mem_req[p].q.data, mem_req[p].q.strb);
                end
            end
            pending = xfer;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            fail_with($sformatf("Timeout: run went past %0d cycles", CYCLE_LIMIT));
        end
    end

    // Feeds each port's queue and holds a request until q_ready
    task automatic run_ports(output int cycles);
        logic [NUM_IN-1:0] busy;
        int                wait_cnt [NUM_IN];
        bit                done;
        busy   = '0;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            for (int p = 0; p < NUM_IN; p++) begin
                if (!busy[p] && port_q[p].size() > 0) begin
                    mem_req[p].q       <= port_q[p].pop_front();
                    mem_req[p].q_valid <= 1'b1;
                    busy[p]     = 1'b1;
                    wait_cnt[p] = 0;
                end else if (!busy[p]) begin
                    mem_req[p].q_valid <= 1'b0;
                end
            end
            @(negedge clk);
            cycles++;
            done = 1'b1;
            for (int p = 0; p < NUM_IN; p++) begin
                if (busy[p] && mem_rsp[p].q_ready) begin
                    busy[p] = 1'b0;
                end else if (busy[p]) begin
                    wait_cnt[p]++;
                    if (wait_cnt[p] > NUM_IN + 2) begin
                        fail_with($sformatf("Port %0d waited over %0d cycles for q_ready",
                                            p, NUM_IN + 2));
                    end
                end
                if (busy[p] || port_q[p].size() > 0) done = 1'b0;
            end
        end
        @(posedge clk);
        for (int p = 0; p < NUM_IN; p++) mem_req[p].q_valid <= 1'b0;
        // Last response is checked on the falling edge in between
        @(posedge clk);
    endtask

    task automatic init_memory();
        int cycles;
        for (int b = 0; b < NUM_OUT; b++) begin
            for (int r = 0; r < ROWS; r++) begin
                queue_req(b % NUM_IN, 1'b1, make_addr(b, r), fill_word(make_addr(b, r)), 4'hf);
            end
        end
        run_ports(cycles);
    endtask

    task automatic write_then_read_partial();
        logic [31:0] addr;
        logic [31:0] old;
        int          cycles;
        addr = make_addr(1, 5);
        old  = fill_word(addr);
        queue_req(0, 1'b1, addr, 32'hdead_beef, 4'b0101);
        queue_req(0, 1'b0, addr, '0, '0);
        run_ports(cycles);
        check_value("cycles", cycles, 2);
        check_value("mem_rsp[0].p.data", last_data[0], {old[31:24], 8'had, old[15:8], 8'hef});
    endtask

    // A stall on any port would add a cycle
    task automatic hit_distinct_banks();
        logic [31:0] addr;
        int          cycles;
        for (int p = 0; p < NUM_IN; p++) begin
            addr = make_addr((p + 2) % NUM_OUT, 10 + p);
            queue_req(p, 1'b1, addr, next_rand(), 4'hf);
            queue_req(p, 1'b0, addr, '0, '0);
        end
        run_ports(cycles);
        check_value("cycles", cycles, 2);
    endtask

    task automatic hit_same_bank();
        int first;
        int cycles;
        first = (last_winner[0] + 1) % NUM_IN;
        grant_log.delete();
        for (int p = 0; p < NUM_IN; p++) queue_req(p, 1'b0, make_addr(0, 30 + p), '0, '0);
        run_ports(cycles);
        check_value("cycles", cycles, NUM_IN);
        check_value("grant count", grant_log.size(), NUM_IN);
        for (int k = 0; k < NUM_IN; k++) begin
            check_value($sformatf("grant_log[%0d]", k), grant_log[k], (first + k) % NUM_IN);
        end
    endtask

    task automatic stream_back_to_back();
        int cycles;
        for (int i = 0; i < 8; i++) begin
            queue_req(0, i < 4, make_addr(2 + i % 2, 20 + i % 4), next_rand(), 4'hf);
        end
        run_ports(cycles);
        check_value("cycles", cycles, 8);
    endtask

    // Small row window so ports collide and revisit words
    task automatic mix_random();
        logic [31:0] addr;
        logic [31:0] ctl;
        int          cycles;
        for (int p = 0; p < NUM_IN; p++) begin
            for (int n = 0; n < RAND_OPS; n++) begin
                addr = make_addr(int'(next_rand() % 32'(NUM_OUT)), int'(next_rand() % 32'd8));
                addr = addr | (next_rand() << ADDR_TOP) | (next_rand() & 32'h3);
                ctl  = next_rand();
                queue_req(p, ctl[0], addr, next_rand(), ctl[7:4]);
            end
        end
        run_ports(cycles);
    endtask

    initial begin
        rst_n   <= 1'b0;
        mem_req <= '0;
        // Arbiter pointers start at port 0
        for (int b = 0; b < NUM_OUT; b++) last_winner[b] = NUM_IN - 1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        init_memory();
        write_then_read_partial();
        hit_distinct_banks();
        hit_same_bank();
        stream_back_to_back();
        mix_random();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
tcdm_pkg.sv
tcdm_rr_arbiter.sv
tcdm_interconnect.sv
tcdm_interconnect_wrap.sv
tcdm_sram_bank.sv
tcdm_cluster_top.sv
tcdm_props.sv
tb_tcdm_cluster.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tcdm_cluster
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) tcdm_consts.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# A $fatal in the testbench gives a non-zero exit status
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
